/* vlog.f */
+incdir+testbench
hw/exe_pkg.sv
hw/exe_stage_reg.sv
hw/exe_alu.sv
hw/exe_except_check.sv
hw/exe_result_path.sv
hw/exe_branch_check.sv
hw/exe_top.sv
testbench/tb_exe.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_exe
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log
SOURCES  = $(wildcard hw/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, then check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "simulation FAILED"; exit 1)
	@echo "simulation PASSED"

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/tb_exe_model.svh */
`ifndef TB_EXE_MODEL_SVH
`define TB_EXE_MODEL_SVH

function automatic word_t compute_alu(alu_ctrl_t ctrl, word_t a, word_t b);
    word_t r;
    r = '0;
    if (ctrl[ALU_ADD])  r = a + b;
    if (ctrl[ALU_SUB])  r = a - b;
    if (ctrl[ALU_SLT])  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    if (ctrl[ALU_SLTU]) r = (a < b) ? 32'd1 : 32'd0;
    if (ctrl[ALU_AND])  r = a & b;
    if (ctrl[ALU_NOR])  r = ~(a | b);
    if (ctrl[ALU_OR])   r = a | b;
    if (ctrl[ALU_XOR])  r = a ^ b;
    // shift amount from src1, shifted value from src2
    if (ctrl[ALU_SLL])  r = b << a[4:0];
    if (ctrl[ALU_SRL])  r = b >> a[4:0];
    if (ctrl[ALU_SRA])  r = $signed(b) >>> a[4:0];
    if (ctrl[ALU_LUI])  r = {b[15:0], 16'h0000};
    return r;
endfunction

// exact sum in 64 bits, overflow when it no longer fits in 32
function automatic logic signed_overflow(alu_ctrl_t ctrl, word_t a, word_t b);
    longint s;
    s = 0;
    if (ctrl[ALU_ADD]) s = longint'($signed(a)) + longint'($signed(b));
    if (ctrl[ALU_SUB]) s = longint'($signed(a)) - longint'($signed(b));
    return s != longint'($signed(s[31:0]));
endfunction

function automatic word_t count_leading(word_t w, logic bit_val);
    int n;
    n = 0;
    for (int i = 31; i >= 0; i--) begin
        if (w[i] != bit_val) break;
        n++;
    end
    return word_t'(n);
endfunction

function automatic logic trap_taken(trap_kind_t kind, word_t a, word_t b);
    logic lt;
    logic ltu;
    lt  = $signed(a) < $signed(b);
    ltu = a < b;
    case (kind)
        TRAP_GE:  return !lt;
        TRAP_GEU: return !ltu;
        TRAP_LT:  return lt;
        TRAP_LTU: return ltu;
        TRAP_EQ:  return a == b;
        TRAP_NE:  return a != b;
        default:  return 1'b0;
    endcase
endfunction

function automatic exe_mem_bus_t expected_mem_bus(id_exe_bus_t b);
    exe_mem_bus_t m;
    logic is_move;
    logic move_cond;
    m.pc        = b.pc;
    m.write_reg = b.write_reg;
    is_move     = b.flags.is_movz || b.flags.is_movn;
    move_cond   = (b.flags.is_movz && b.src2 == 0) || (b.flags.is_movn && b.src2 != 0);
    if (b.flags.is_clo) m.result = count_leading(b.src1, 1'b1);
    else if (b.flags.is_clz) m.result = count_leading(b.src1, 1'b0);
    else if (move_cond) m.result = b.src1;
    else m.result = compute_alu(b.alu_ctrl, b.src1, b.src2);
    m.reg_write = is_move ? move_cond : b.reg_write;
    // kseg0 and kseg1 drop their top three bits
    if (!b.flags.is_mem) m.paddr = '0;
    else if (m.result[31:29] inside {SEG_UNMAPPED_LO, SEG_UNMAPPED_HI})
        m.paddr = {3'b000, m.result[28:0]};
    else m.paddr = m.result;
    m.ex_info = '0;
    if (b.ex_info.is_ex) m.ex_info = b.ex_info;
    else if (b.flags.add_sub_sign && signed_overflow(b.alu_ctrl, b.src1, b.src2))
        m.ex_info = '{is_ex: 1'b1, code: EXC_OV};
    else if (trap_taken(b.flags.trap_kind, b.src1, b.src2))
        m.ex_info = '{is_ex: 1'b1, code: EXC_TR};
    return m;
endfunction

// only called for a valid item
function automatic branch_fix_t expected_branch(id_exe_bus_t b, word_t prev_pc);
    branch_fix_t f;
    logic fail;
    fail = (b.flags.predict_dir != b.flags.branch_hit)
        || (b.flags.predict_dir && b.flags.is_jr && b.branch_next_pc != b.btb_pc);
    f.ready      = fail && b.flags.is_branch;
    f.flush      = b.flags.predict_dir && !b.flags.branch_hit && b.flags.is_branch;
    f.target     = b.flags.branch_hit ? b.branch_next_pc : b.pc + 32'd8;
    f.predict_wr = b.pc != prev_pc;
    return f;
endfunction

`endif

/* testbench/tb_exe.sv */
`timescale 1ns/1ns

module tb_exe
    import exe_pkg::*;
();

    `include "tb_exe_model.svh"

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int N_TESTS      = 2000;
    localparam int WATCHDOG_NS  = N_TESTS * 4 * CLK_PERIOD;

    logic         clk;
    logic         reset;
    logic         flush_i;
    logic         id_valid_i;
    logic         mem_allowin_i;
    id_exe_bus_t  id_bus_i;
    logic         exe_allowin_o;
    logic         exe_valid_o;
    exe_mem_bus_t mem_bus_o;
    branch_fix_t  branch_o;

    // model state holding at most one item
    id_exe_bus_t  held_q[$];
    word_t        held_pc;
    word_t        last_pc;
    exe_mem_bus_t prev_mem;
    logic         was_stalled;

    exe_top UUT (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush_i),
        .id_valid_i    (id_valid_i),
        .mem_allowin_i (mem_allowin_i),
        .id_bus_i      (id_bus_i),
        .exe_allowin_o (exe_allowin_o),
        .exe_valid_o   (exe_valid_o),
        .mem_bus_o     (mem_bus_o),
        .branch_o      (branch_o)
    );

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_mem_bus(string name, exe_mem_bus_t exp, exe_mem_bus_t act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_branch(string name, branch_fix_t exp, branch_fix_t act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_strobe(string name, logic exp, logic act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic id_exe_bus_t random_bus();
        id_exe_bus_t b;
        int kind;
        int op;
        b      = '0;
        b.pc   = $urandom() & 32'hffff_fffc;
        kind   = $urandom_range(7, 0);
        // corner words for clo/clz, random otherwise
        case (kind)
            0: b.src1 = '0;
            1: b.src1 = '1;
            2: b.src1 = ~(32'hffff_ffff >> $urandom_range(31, 0));
            3: b.src1 = 32'hffff_ffff >> $urandom_range(31, 0);
            default: b.src1 = $urandom();
        endcase
        kind   = $urandom_range(7, 0);
        b.src2 = (kind < 2) ? '0 : (kind == 2) ? b.src1 : $urandom();
        b.alu_ctrl = alu_ctrl_t'(1) << $urandom_range(11, 0);
        op = $urandom_range(9, 0);
        b.flags.trap_kind    = trap_kind_t'($urandom_range(6, 0));
        b.flags.add_sub_sign = 1'($urandom());
        b.flags.is_clo       = op == 0;
        b.flags.is_clz       = op == 1;
        b.flags.is_movz      = op == 2;
        b.flags.is_movn      = op == 3;
        b.flags.is_mem       = 1'($urandom());
        b.flags.is_branch    = 1'($urandom());
        b.flags.is_jr        = 1'($urandom());
        b.flags.predict_dir  = 1'($urandom());
        b.flags.branch_hit   = 1'($urandom());
        b.write_reg          = reg_addr_t'($urandom());
        b.reg_write          = 1'($urandom());
        b.ex_info.is_ex      = $urandom_range(7, 0) == 0;
        b.ex_info.code       = exc_code_t'($urandom());
        b.branch_next_pc     = $urandom() & 32'hffff_fffc;
        b.btb_pc = 1'($urandom()) ? b.branch_next_pc : $urandom() & 32'hffff_fffc;
        return b;
    endfunction

    task automatic check_cycle(int i);
        logic held;
        held = held_q.size() != 0;
        check_strobe($sformatf("cycle %0d valid", i), held, exe_valid_o);
        check_strobe($sformatf("cycle %0d allowin", i), !held || mem_allowin_i, exe_allowin_o);
        if (was_stalled) begin
            check_mem_bus($sformatf("cycle %0d hold", i), prev_mem, mem_bus_o);
        end
        if (held) begin
            check_mem_bus($sformatf("cycle %0d mem_bus", i), expected_mem_bus(held_q[0]),
                          mem_bus_o);
            check_branch($sformatf("cycle %0d branch", i),
                         expected_branch(held_q[0], last_pc), branch_o);
        end
    endtask

    // what the next rising edge does with the inputs now on the wires
    task automatic advance_model();
        logic held;
        logic capture;
        held        = held_q.size() != 0;
        capture     = id_valid_i && (!held || mem_allowin_i) && !flush_i;
        was_stalled = held && !mem_allowin_i && !flush_i;
        prev_mem    = mem_bus_o;
        last_pc     = held_pc;
        if (capture) held_pc = id_bus_i.pc;
        if (flush_i) begin
            held_q.delete();
        end else begin
            if (held && mem_allowin_i) void'(held_q.pop_front());
            if (capture) held_q.push_back(id_bus_i);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("timeout: the run did not finish in the expected time");
    end

    initial begin
        void'($urandom(32'h1d88));
        reset         = 1'b1;
        flush_i       = 1'b0;
        id_valid_i    = 1'b0;
        mem_allowin_i = 1'b0;
        id_bus_i      = '0;
        held_pc       = '0;
        last_pc       = '0;
        prev_mem      = '0;
        was_stalled   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_strobe("reset valid", 1'b0, exe_valid_o);
        check_strobe("reset ready", 1'b0, branch_o.ready);
        check_strobe("reset flush", 1'b0, branch_o.flush);
        check_strobe("reset predict_wr", 1'b0, branch_o.predict_wr);
        for (int i = 0; i < N_TESTS; i++) begin
            @(posedge clk);
            id_valid_i    <= $urandom_range(3, 0) != 0;
            mem_allowin_i <= $urandom_range(3, 0) != 0;
            flush_i       <= $urandom_range(31, 0) == 0;
            id_bus_i      <= random_bus();
            @(negedge clk);
            check_cycle(i);
            advance_model();
        end
        @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

/* hw/exe_top.sv */
`timescale 1ns/1ns

module exe_top
    import exe_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         flush_i,
    input  logic         id_valid_i,
    input  logic         mem_allowin_i,
    input  id_exe_bus_t  id_bus_i,
    output logic         exe_allowin_o,
    output logic         exe_valid_o,
    output exe_mem_bus_t mem_bus_o,
    output branch_fix_t  branch_o
);

    id_exe_bus_t exe_bus;
    word_t       alu_result;
    word_t       cloz_count;
    logic        alu_overflow;
    logic        cmp_lt;
    logic        cmp_ltu;
    logic        cmp_eq;

    exe_stage_reg u_stage_reg (
        .clk           (clk),
        .reset         (reset),
        .flush_i       (flush_i),
        .id_valid_i    (id_valid_i),
        .mem_allowin_i (mem_allowin_i),
        .id_bus_i      (id_bus_i),
        .valid_o       (exe_valid_o),
        .allowin_o     (exe_allowin_o),
        .bus_o         (exe_bus)
    );

    exe_alu u_alu (
        .alu_ctrl_i (exe_bus.alu_ctrl),
        .src1_i     (exe_bus.src1),
        .src2_i     (exe_bus.src2),
        .is_clo_i   (exe_bus.flags.is_clo),
        .result_o   (alu_result),
        .overflow_o (alu_overflow),
        .lt_o       (cmp_lt),
        .ltu_o      (cmp_ltu),
        .eq_o       (cmp_eq),
        .count_o    (cloz_count)
    );

    exe_except_check u_except_check (
        .ex_in_i        (exe_bus.ex_info),
        .trap_kind_i    (exe_bus.flags.trap_kind),
        .add_sub_sign_i (exe_bus.flags.add_sub_sign),
        .overflow_i     (alu_overflow),
        .lt_i           (cmp_lt),
        .ltu_i          (cmp_ltu),
        .eq_i           (cmp_eq),
        .ex_out_o       (mem_bus_o.ex_info)
    );

    exe_result_path u_result_path (
        .flags_i      (exe_bus.flags),
        .src1_i       (exe_bus.src1),
        .src2_i       (exe_bus.src2),
        .alu_result_i (alu_result),
        .count_i      (cloz_count),
        .reg_write_i  (exe_bus.reg_write),
        .result_o     (mem_bus_o.result),
        .paddr_o      (mem_bus_o.paddr),
        .reg_write_o  (mem_bus_o.reg_write)
    );

    exe_branch_check u_branch_check (
        .clk              (clk),
        .reset            (reset),
        .valid_i          (exe_valid_o),
        .flags_i          (exe_bus.flags),
        .pc_i             (exe_bus.pc),
        .branch_next_pc_i (exe_bus.branch_next_pc),
        .btb_pc_i         (exe_bus.btb_pc),
        .fix_o            (branch_o)
    );

    assign mem_bus_o.pc        = exe_bus.pc;
    assign mem_bus_o.write_reg = exe_bus.write_reg;

endmodule

/* hw/exe_branch_check.sv */
`timescale 1ns/1ns

module exe_branch_check
    import exe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        valid_i,
    input  inst_flags_t flags_i,
    input  word_t       pc_i,
    input  word_t       branch_next_pc_i,
    input  word_t       btb_pc_i,
    output branch_fix_t fix_o
);

    word_t last_pc;
    logic  jr_miss;
    logic  predict_fail;
    logic  pc_changed;

    // direction right but jr went somewhere other than the btb said
    assign jr_miss      = flags_i.predict_dir && flags_i.is_jr
                       && (branch_next_pc_i != btb_pc_i);
    assign predict_fail = (flags_i.predict_dir ^ flags_i.branch_hit) || jr_miss;

    assign fix_o.ready = predict_fail && valid_i && flags_i.is_branch;

    // predicted taken but falls through
    assign fix_o.flush = flags_i.predict_dir && !flags_i.branch_hit
                      && flags_i.is_branch && valid_i;

    // not taken resumes after the delay slot
    assign fix_o.target = flags_i.branch_hit ? branch_next_pc_i : pc_i + 32'd8;

    // predictor is written once per new pc
    assign pc_changed       = pc_i != last_pc;
    assign fix_o.predict_wr = pc_changed;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_pc <= '0;
        end else if (pc_changed) begin
            last_pc <= pc_i;
        end
    end

endmodule

/* hw/exe_result_path.sv */
`timescale 1ns/1ns

module exe_result_path
    import exe_pkg::*;
(
    input  inst_flags_t flags_i,
    input  word_t       src1_i,
    input  word_t       src2_i,
    input  word_t       alu_result_i,
    input  word_t       count_i,
    input  logic        reg_write_i,
    output word_t       result_o,
    output word_t       paddr_o,
    output logic        reg_write_o
);

    logic       is_move;
    logic       src2_zero;
    logic       do_move;
    logic       is_cloz;
    logic [2:0] seg;
    logic       unmapped;

    assign src2_zero = src2_i == '0;
    assign is_move   = flags_i.is_movz || flags_i.is_movn;
    assign do_move   = (flags_i.is_movz && src2_zero) || (flags_i.is_movn && !src2_zero);
    assign is_cloz   = flags_i.is_clo || flags_i.is_clz;

    always_comb begin
        if (is_cloz) begin
            result_o = count_i;
        end else if (do_move) begin
            result_o = src1_i;
        end else begin
            result_o = alu_result_i;
        end
    end

    // a move that is not taken leaves the register file alone
    assign reg_write_o = is_move ? do_move : reg_write_i;

    // kseg0/kseg1 map directly onto the low 512 MB
    assign seg      = result_o[31:29];
    assign unmapped = (seg == SEG_UNMAPPED_LO) || (seg == SEG_UNMAPPED_HI);

    always_comb begin
        if (!flags_i.is_mem) begin
            paddr_o = '0;
        end else if (unmapped) begin
            paddr_o = {3'b000, result_o[28:0]};
        end else begin
            paddr_o = result_o;
        end
    end

endmodule

/* hw/exe_except_check.sv */
`timescale 1ns/1ns

module exe_except_check
    import exe_pkg::*;
(
    input  ex_info_t   ex_in_i,
    input  trap_kind_t trap_kind_i,
    input  logic       add_sub_sign_i,
    input  logic       overflow_i,
    input  logic       lt_i,
    input  logic       ltu_i,
    input  logic       eq_i,
    output ex_info_t   ex_out_o
);

    logic trap_hit;
    logic overflow_ex;

    always_comb begin
        case (trap_kind_i)
            TRAP_GE:  trap_hit = !lt_i;
            TRAP_GEU: trap_hit = !ltu_i;
            TRAP_LT:  trap_hit = lt_i;
            TRAP_LTU: trap_hit = ltu_i;
            TRAP_EQ:  trap_hit = eq_i;
            TRAP_NE:  trap_hit = !eq_i;
            default:  trap_hit = 1'b0;
        endcase
    end

    // addu/subu never raise overflow
    assign overflow_ex = overflow_i && add_sub_sign_i;

    // earlier stages win, then overflow, then trap
    always_comb begin
        if (ex_in_i.is_ex) begin
            ex_out_o = ex_in_i;
        end else if (overflow_ex) begin
            ex_out_o.is_ex = 1'b1;
            ex_out_o.code  = EXC_OV;
        end else if (trap_hit) begin
            ex_out_o.is_ex = 1'b1;
            ex_out_o.code  = EXC_TR;
        end else begin
            ex_out_o = '0;
        end
    end

endmodule

/* hw/exe_alu.sv */
`timescale 1ns/1ns

module exe_alu
    import exe_pkg::*;
(
    input  alu_ctrl_t alu_ctrl_i,
    input  word_t     src1_i,
    input  word_t     src2_i,
    input  logic      is_clo_i,
    output word_t     result_o,
    output logic      overflow_o,
    output logic      lt_o,
    output logic      ltu_o,
    output logic      eq_o,
    output word_t     count_o
);

    logic        op_add;
    logic        op_sub;
    logic        do_sub;
    word_t       adder_b;
    word_t       sum;
    word_t       slt_res;
    word_t       sltu_res;
    word_t       sll_res;
    word_t       srl_res;
    word_t       sra_res;
    word_t       lui_res;
    logic [4:0]  sa;
    word_t       cloz_val;

    assign op_add = alu_ctrl_i[ALU_ADD];
    assign op_sub = alu_ctrl_i[ALU_SUB];
    assign do_sub = op_sub || alu_ctrl_i[ALU_SLT] || alu_ctrl_i[ALU_SLTU];

    // a - b as a + ~b + 1
    assign adder_b = do_sub ? ~src2_i : src2_i;
    assign sum     = src1_i + adder_b + word_t'(do_sub);

    // same-sign operands giving an opposite-sign sum
    assign overflow_o = (op_add || op_sub)
                     && (src1_i[31] == adder_b[31])
                     && (sum[31] != src1_i[31]);

    assign lt_o  = $signed(src1_i) < $signed(src2_i);
    assign ltu_o = src1_i < src2_i;
    assign eq_o  = src1_i == src2_i;

    assign slt_res  = {31'b0, lt_o};
    assign sltu_res = {31'b0, ltu_o};

    // shift amount comes from src1, the shifted value from src2
    assign sa      = src1_i[4:0];
    assign sll_res = src2_i << sa;
    assign srl_res = src2_i >> sa;
    assign sra_res = word_t'($signed(src2_i) >>> sa);
    assign lui_res = {src2_i[15:0], 16'b0};

    assign result_o = ({32{op_add | op_sub}}         & sum)
                    | ({32{alu_ctrl_i[ALU_SLT]}}     & slt_res)
                    | ({32{alu_ctrl_i[ALU_SLTU]}}    & sltu_res)
                    | ({32{alu_ctrl_i[ALU_AND]}}     & (src1_i & src2_i))
                    | ({32{alu_ctrl_i[ALU_NOR]}}     & ~(src1_i | src2_i))
                    | ({32{alu_ctrl_i[ALU_OR]}}      & (src1_i | src2_i))
                    | ({32{alu_ctrl_i[ALU_XOR]}}     & (src1_i ^ src2_i))
                    | ({32{alu_ctrl_i[ALU_SLL]}}     & sll_res)
                    | ({32{alu_ctrl_i[ALU_SRL]}}     & srl_res)
                    | ({32{alu_ctrl_i[ALU_SRA]}}     & sra_res)
                    | ({32{alu_ctrl_i[ALU_LUI]}}     & lui_res);

    // leading ones become leading zeros after inversion
    assign cloz_val = is_clo_i ? ~src1_i : src1_i;

    always_comb begin
        count_o = 32'd32;
        for (int i = 0; i < 32; i++) begin
            if (cloz_val[i]) begin
                count_o = word_t'(31 - i);
            end
        end
    end

    // decode in id must never select two operations at once
    always_comb begin
        assert ($isunknown(alu_ctrl_i) || $onehot0(alu_ctrl_i))
        else $error("alu control not one-hot: %b", alu_ctrl_i);
    end

endmodule

/* hw/exe_stage_reg.sv */
`timescale 1ns/1ns

module exe_stage_reg
    import exe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush_i,
    input  logic        id_valid_i,
    input  logic        mem_allowin_i,
    input  id_exe_bus_t id_bus_i,
    output logic        valid_o,
    output logic        allowin_o,
    output id_exe_bus_t bus_o
);

    logic        valid;
    logic        capture;
    id_exe_bus_t bus_q;

    // every instruction finishes in one cycle, so only mem decides
    assign allowin_o = !valid || mem_allowin_i;
    assign capture   = id_valid_i && allowin_o && !flush_i;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            valid <= 1'b0;
        end else if (allowin_o) begin
            valid <= id_valid_i;
        end
    end

    // a zero pc after reset matches the predictor's last-pc register
    always_ff @(posedge clk) begin
        if (reset) begin
            bus_q <= '0;
        end else if (capture) begin
            bus_q <= id_bus_i;
        end
    end

    assign valid_o = valid;
    assign bus_o   = bus_q;

    // a flush empties the stage on the following edge
    flush_clears_valid: assert property (
        @(posedge clk) disable iff (reset)
        flush_i |=> !valid_o
    ) else $error("exe stage still valid after flush");

endmodule

/* hw/exe_pkg.sv */
package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_ctrl_t;
    typedef logic [2:0]  trap_kind_t;
    typedef logic [4:0]  exc_code_t;

    // one-hot alu control bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam trap_kind_t TRAP_NONE = 3'd0;
    localparam trap_kind_t TRAP_GE   = 3'd1;
    localparam trap_kind_t TRAP_GEU  = 3'd2;
    localparam trap_kind_t TRAP_LT   = 3'd3;
    localparam trap_kind_t TRAP_LTU  = 3'd4;
    localparam trap_kind_t TRAP_EQ   = 3'd5;
    localparam trap_kind_t TRAP_NE   = 3'd6;

    localparam exc_code_t EXC_OV = 5'd12;
    localparam exc_code_t EXC_TR = 5'd13;

    // top three address bits of kseg0 / kseg1
    localparam logic [2:0] SEG_UNMAPPED_LO = 3'b100;
    localparam logic [2:0] SEG_UNMAPPED_HI = 3'b101;

    typedef struct packed {
        logic      is_ex;
        exc_code_t code;
    } ex_info_t;

    typedef struct packed {
        trap_kind_t trap_kind;
        logic       add_sub_sign;
        logic       is_clo;
        logic       is_clz;
        logic       is_movz;
        logic       is_movn;
        logic       is_mem;
        logic       is_branch;
        logic       is_jr;
        logic       predict_dir;
        logic       branch_hit;
    } inst_flags_t;

    typedef struct packed {
        word_t       pc;
        word_t       src1;
        word_t       src2;
        alu_ctrl_t   alu_ctrl;
        inst_flags_t flags;
        reg_addr_t   write_reg;
        logic        reg_write;
        ex_info_t    ex_info;
        word_t       branch_next_pc;
        word_t       btb_pc;
    } id_exe_bus_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     paddr;
        reg_addr_t write_reg;
        logic      reg_write;
        ex_info_t  ex_info;
    } exe_mem_bus_t;

    // redirect request back to fetch and predictor update strobe
    typedef struct packed {
        logic  ready;
        logic  flush;
        word_t target;
        logic  predict_wr;
    } branch_fix_t;

endpackage
